// File: verilog/bf_pkg.sv
/*
 * beamforming combiner shared definitions
 * sample and weight widths, the weight's fixed-point format and the
 * channel count, plus the signed types built from them
 */
package bf_pkg;

    // one real or imaginary sample component, two's complement
    localparam int SAMPLE_WIDTH = 16;

    // one real or imaginary weight component, two's complement
    localparam int WEIGHT_WIDTH = 8;

    // weights are signed Q0.7 so 64 is one half and 127 is just under one
    localparam int WEIGHT_FRAC = 7;

    // antenna channels summed by the combiner
    localparam int CHANNELS = 4;

    // samples carried side by side on one beat of every channel
    localparam int DEFAULT_LANES = 8;

    // one part of a complex sample, also the width of every result
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // one part of a complex weight
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // full-precision product of a sample part and a weight part
    // this never overflows, so scaling happens only after the multiply
    typedef logic signed [SAMPLE_WIDTH+WEIGHT_WIDTH-1:0] product_t;

endpackage

// File: verilog/bf_lane_cmul.sv
/*
 * single-lane complex multiplier
 * multiplies one complex sample by one complex Q0.7 weight in two
 * register stages and scales the result back to sample width
 */
`timescale 1ns/10ps

module bf_lane_cmul (
    input  logic             clock,
    input  logic             resetn,
    input  bf_pkg::sample_t  sample_re,
    input  bf_pkg::sample_t  sample_im,
    input  bf_pkg::weight_t  coef_re,
    input  bf_pkg::weight_t  coef_im,
    output bf_pkg::sample_t  result_re,
    output bf_pkg::sample_t  result_im
);

    import bf_pkg::*;

    // stage one holds the four raw cross products at full width
    product_t prod_rr;
    product_t prod_ii;
    product_t prod_ri;
    product_t prod_ir;

    // products after the fixed-point shift, already cut to sample width
    sample_t scaled_rr;
    sample_t scaled_ii;
    sample_t scaled_ri;
    sample_t scaled_ir;

    // both operands are signed, so they are sign-extended to the product width
    // before multiplying and the product is exact
    always_ff @(posedge clock) begin
        if (!resetn) begin
            prod_rr <= '0;
            prod_ii <= '0;
            prod_ri <= '0;
            prod_ir <= '0;
        end else begin
            prod_rr <= sample_re * coef_re;
            prod_ii <= sample_im * coef_im;
            prod_ri <= sample_re * coef_im;
            prod_ir <= sample_im * coef_re;
        end
    end

    // arithmetic shift drops the weight's fraction and rounds toward minus
    // infinity, the cast then keeps the low sample bits
    assign scaled_rr = sample_t'(prod_rr >>> WEIGHT_FRAC);
    assign scaled_ii = sample_t'(prod_ii >>> WEIGHT_FRAC);
    assign scaled_ri = sample_t'(prod_ri >>> WEIGHT_FRAC);
    assign scaled_ir = sample_t'(prod_ir >>> WEIGHT_FRAC);

    // stage two forms (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    // every term is sample width, so the sum and difference wrap there
    always_ff @(posedge clock) begin
        if (!resetn) begin
            result_re <= '0;
            result_im <= '0;
        end else begin
            result_re <= scaled_rr - scaled_ii;
            result_im <= scaled_ri + scaled_ir;
        end
    end

endmodule

// File: verilog/bf_channel.sv
/*
 * beamforming channel
 * applies one complex weight to every lane of an input beat and keeps
 * valid and last lined up with the two-cycle multiplier
 */
`timescale 1ns/10ps

module bf_channel #(
    parameter int LANES = bf_pkg::DEFAULT_LANES
) (
    input  logic             clock,
    input  logic             resetn,
    input  logic             valid,
    input  logic             last,
    input  bf_pkg::sample_t  beat_re [LANES],
    input  bf_pkg::sample_t  beat_im [LANES],
    input  bf_pkg::weight_t  weight_re,
    input  bf_pkg::weight_t  weight_im,
    output logic             weighted_valid,
    output logic             weighted_last,
    output bf_pkg::sample_t  weighted_re [LANES],
    output bf_pkg::sample_t  weighted_im [LANES]
);

    // bit 0 matches the product stage, bit 1 matches the result stage
    logic [1:0] valid_pipe;
    logic [1:0] last_pipe;

    // the multipliers run every cycle whether or not the beat is valid
    // so validity only has to follow the same two register delays
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_pipe <= 2'b00;
            last_pipe  <= 2'b00;
        end else begin
            valid_pipe <= {valid_pipe[0], valid};
            last_pipe  <= {last_pipe[0], last};
        end
    end

    assign weighted_valid = valid_pipe[1];
    assign weighted_last  = last_pipe[1];

    // one multiplier per lane, all sharing this channel's weight
    // the weight feeds the product stage directly, so it is taken on the
    // same edge as the samples of the beat it belongs to
    for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
        bf_lane_cmul u_cmul (
            .clock     (clock),
            .resetn    (resetn),
            .sample_re (beat_re[lane]),
            .sample_im (beat_im[lane]),
            .coef_re   (weight_re),
            .coef_im   (weight_im),
            .result_re (weighted_re[lane]),
            .result_im (weighted_im[lane])
        );
    end

endmodule

// File: verilog/bf_combiner.sv
/*
 * beamforming combiner output stage
 * adds the weighted beats of all channels lane by lane and registers the
 * result only when every channel has a valid beat on the same cycle
 */
`timescale 1ns/10ps

module bf_combiner #(
    parameter int LANES = bf_pkg::DEFAULT_LANES
) (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic [bf_pkg::CHANNELS-1:0]   ch_valid,
    input  logic                          first_last,
    input  bf_pkg::sample_t               ch_re [bf_pkg::CHANNELS][LANES],
    input  bf_pkg::sample_t               ch_im [bf_pkg::CHANNELS][LANES],
    output logic                          out_valid,
    output logic                          out_last,
    output bf_pkg::sample_t               out_re [LANES],
    output bf_pkg::sample_t               out_im [LANES]
);

    import bf_pkg::*;

    // enough headroom that the running sum of all channels cannot overflow
    localparam int SUM_WIDTH = SAMPLE_WIDTH + $clog2(CHANNELS);

    typedef logic signed [SUM_WIDTH-1:0] sum_t;

    logic    all_valid;
    sample_t sum_re [LANES];
    sample_t sum_im [LANES];

    // a beat missing from any channel is dropped as a whole
    assign all_valid = &ch_valid;

    // each lane is summed at full width and only then wrapped to sample width
    always_comb begin
        sum_t acc_re;
        sum_t acc_im;
        for (int lane = 0; lane < LANES; lane++) begin
            acc_re = '0;
            acc_im = '0;
            for (int ch = 0; ch < CHANNELS; ch++) begin
                acc_re = acc_re + sum_t'(ch_re[ch][lane]);
                acc_im = acc_im + sum_t'(ch_im[ch][lane]);
            end
            sum_re[lane] = sample_t'(acc_re);
            sum_im[lane] = sample_t'(acc_im);
        end
    end

    // the data is forced to zero on every cycle without a combined beat
    // so an idle output bus always reads as zero
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            for (int lane = 0; lane < LANES; lane++) begin
                out_re[lane] <= '0;
                out_im[lane] <= '0;
            end
        end else if (all_valid) begin
            out_valid <= 1'b1;
            // the frame boundary follows channel 0
            out_last  <= first_last;
            for (int lane = 0; lane < LANES; lane++) begin
                out_re[lane] <= sum_re[lane];
                out_im[lane] <= sum_im[lane];
            end
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            for (int lane = 0; lane < LANES; lane++) begin
                out_re[lane] <= '0;
                out_im[lane] <= '0;
            end
        end
    end

endmodule

// File: verilog/bf_top.sv
/*
 * four-channel complex beamforming combiner
 * weights every channel's beat by its own complex weight and sums the
 * channels into one output beat, two cycles after the edge that samples it
 */
`timescale 1ns/10ps

module bf_top #(
    parameter int LANES = bf_pkg::DEFAULT_LANES
) (
    input  logic                          clock,
    input  logic                          resetn,

    // one complex weight per channel, taken with that channel's beat
    input  bf_pkg::weight_t               weight_re [bf_pkg::CHANNELS],
    input  bf_pkg::weight_t               weight_im [bf_pkg::CHANNELS],

    // per-channel input beats, indexed by channel then lane
    input  logic [bf_pkg::CHANNELS-1:0]   in_valid,
    input  logic [bf_pkg::CHANNELS-1:0]   in_last,
    input  bf_pkg::sample_t               in_re [bf_pkg::CHANNELS][LANES],
    input  bf_pkg::sample_t               in_im [bf_pkg::CHANNELS][LANES],

    // combined output beat, there is no back-pressure
    output logic                          out_valid,
    output logic                          out_last,
    output bf_pkg::sample_t               out_re [LANES],
    output bf_pkg::sample_t               out_im [LANES]
);

    import bf_pkg::*;

    // weighted beats from each channel, two cycles behind the inputs
    logic [CHANNELS-1:0] ch_valid;
    logic [CHANNELS-1:0] ch_last;
    sample_t             ch_re [CHANNELS][LANES];
    sample_t             ch_im [CHANNELS][LANES];

    // channels are independent, each with its own weight and valid
    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
        bf_channel #(
            .LANES (LANES)
        ) u_channel (
            .clock          (clock),
            .resetn         (resetn),
            .valid          (in_valid[ch]),
            .last           (in_last[ch]),
            .beat_re        (in_re[ch]),
            .beat_im        (in_im[ch]),
            .weight_re      (weight_re[ch]),
            .weight_im      (weight_im[ch]),
            .weighted_valid (ch_valid[ch]),
            .weighted_last  (ch_last[ch]),
            .weighted_re    (ch_re[ch]),
            .weighted_im    (ch_im[ch])
        );
    end

    // only channel 0 decides where a frame ends
    // the other channels' last bits are carried but not combined
    bf_combiner #(
        .LANES (LANES)
    ) u_combiner (
        .clock      (clock),
        .resetn     (resetn),
        .ch_valid   (ch_valid),
        .first_last (ch_last[0]),
        .ch_re      (ch_re),
        .ch_im      (ch_im),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_re     (out_re),
        .out_im     (out_im)
    );

endmodule

// File: bench/bf_tb_model.svh
/*
 * reference model for the beamforming combiner testbench
 * computes one weighted sample part from its sample and weight parts
 */
`ifndef BF_TB_MODEL_SVH
`define BF_TB_MODEL_SVH

// one product scaled back to sample width
// the weight is Q0.7, so the product carries seven fraction bits
function automatic part_bits_t scaled_product(input int sample, input int weight);
    int product;
    int shifted;
    product = sample * weight;
    // an arithmetic shift of a signed int rounds toward minus infinity
    shifted = product >>> bf_pkg::WEIGHT_FRAC;
    return part_bits_t'(shifted);
endfunction

// real part of (a + jb)(c + jd), wrapped to sample width
function automatic part_bits_t weighted_real(input int s_re, input int s_im,
                                             input int w_re, input int w_im);
    part_bits_t term_rr;
    part_bits_t term_ii;
    term_rr = scaled_product(s_re, w_re);
    term_ii = scaled_product(s_im, w_im);
    return term_rr - term_ii;
endfunction

// imaginary part of (a + jb)(c + jd), wrapped to sample width
function automatic part_bits_t weighted_imag(input int s_re, input int s_im,
                                             input int w_re, input int w_im);
    part_bits_t term_ri;
    part_bits_t term_ir;
    term_ri = scaled_product(s_re, w_im);
    term_ir = scaled_product(s_im, w_re);
    return term_ri + term_ir;
endfunction

`endif

// File: bench/bf_tb.sv
/*
 * testbench for the four-channel beamforming combiner
 * runs directed cases against bf_top and checks every output beat
 * against a reference model of the fixed-point arithmetic
 */
`timescale 1ns/10ps

module bf_tb;

    localparam int LANES = bf_pkg::DEFAULT_LANES;
    localparam int CHANNELS = bf_pkg::CHANNELS;
    localparam int BEAT_BITS = LANES * bf_pkg::SAMPLE_WIDTH;

    typedef logic [bf_pkg::SAMPLE_WIDTH-1:0] part_bits_t;

    logic                clock;
    logic                resetn;
    bf_pkg::weight_t     weight_re [CHANNELS];
    bf_pkg::weight_t     weight_im [CHANNELS];
    logic [CHANNELS-1:0] in_valid;
    logic [CHANNELS-1:0] in_last;
    bf_pkg::sample_t     in_re [CHANNELS][LANES];
    bf_pkg::sample_t     in_im [CHANNELS][LANES];
    logic                out_valid;
    logic                out_last;
    bf_pkg::sample_t     out_re [LANES];
    bf_pkg::sample_t     out_im [LANES];

    // expected output beats in arrival order, lane 0 in the low bits
    logic [BEAT_BITS-1:0] exp_re_q [$];
    logic [BEAT_BITS-1:0] exp_im_q [$];
    logic                 exp_last_q [$];

    int          errors = 0;
    int          checks = 0;
    int          beats_seen = 0;
    logic [31:0] lfsr_state = 32'h9506_4f65;

    `include "bf_tb_model.svh"

    bf_top #(
        .LANES (LANES)
    ) uut (
        .clock     (clock),
        .resetn    (resetn),
        .weight_re (weight_re),
        .weight_im (weight_im),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_re     (in_re),
        .in_im     (in_im),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_re    (out_re),
        .out_im    (out_im)
    );

    always #2 clock = ~clock;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_next_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++)
            value = {value[30:0], lfsr_next_bit()};
        return value;
    endfunction

    // fixed samples that include both ends of the sample range
    function automatic bf_pkg::sample_t known_sample(input int idx);
        case (idx % 8)
            0: return 16'sd100;
            1: return -16'sd100;
            2: return 16'sd1;
            3: return -16'sd1;
            4: return 16'sd32767;
            5: return -16'sd32768;
            6: return 16'sd255;
            default: return -16'sd3;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    // every output cycle is checked here, valid beats against the model
    always @(negedge clock) begin : output_monitor
        logic [BEAT_BITS-1:0] beat_re;
        logic [BEAT_BITS-1:0] beat_im;
        logic                 beat_last;
        part_bits_t           got_re;
        part_bits_t           got_im;
        if (resetn) begin
            if (out_valid) begin
                beats_seen++;
                if (exp_re_q.size() == 0) begin
                    errors++;
                    $display("output beat arrived when none was expected");
                end else begin
                    beat_re = exp_re_q.pop_front();
                    beat_im = exp_im_q.pop_front();
                    beat_last = exp_last_q.pop_front();
                    for (int lane = 0; lane < LANES; lane++) begin
                        got_re = out_re[lane];
                        got_im = out_im[lane];
                        check_value($sformatf("out_re[%0d]", lane), {16'h0000, got_re},
                                    {16'h0000, beat_re[lane*16 +: 16]});
                        check_value($sformatf("out_im[%0d]", lane), {16'h0000, got_im},
                                    {16'h0000, beat_im[lane*16 +: 16]});
                    end
                    check_value("out_last", {31'd0, out_last}, {31'd0, beat_last});
                end
            end else begin
                // an idle bus must read as zero
                check_value("out_last", {31'd0, out_last}, 32'd0);
                for (int lane = 0; lane < LANES; lane++) begin
                    got_re = out_re[lane];
                    got_im = out_im[lane];
                    check_value($sformatf("out_re[%0d]", lane), {16'h0000, got_re}, 32'd0);
                    check_value($sformatf("out_im[%0d]", lane), {16'h0000, got_im}, 32'd0);
                end
            end
        end
    end

    task automatic start_case(input string name);
        $display("case: %s", name);
        beats_seen = 0;
    endtask

    task automatic randomize_inputs();
        for (int ch = 0; ch < CHANNELS; ch++) begin
            weight_re[ch] = 8'(random_bits(8));
            weight_im[ch] = 8'(random_bits(8));
            for (int lane = 0; lane < LANES; lane++) begin
                in_re[ch][lane] = 16'(random_bits(16));
                in_im[ch][lane] = 16'(random_bits(16));
            end
        end
    endtask

    // presents the current inputs for one edge, the caller has already set them
    // when use_model is set and all channels are valid, the model's beat is queued
    task automatic drive_beat(input logic use_model);
        logic [BEAT_BITS-1:0] beat_re;
        logic [BEAT_BITS-1:0] beat_im;
        part_bits_t           acc_re;
        part_bits_t           acc_im;
        if (use_model && &in_valid) begin
            for (int lane = 0; lane < LANES; lane++) begin
                acc_re = '0;
                acc_im = '0;
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    acc_re = acc_re + weighted_real(in_re[ch][lane], in_im[ch][lane],
                                                    weight_re[ch], weight_im[ch]);
                    acc_im = acc_im + weighted_imag(in_re[ch][lane], in_im[ch][lane],
                                                    weight_re[ch], weight_im[ch]);
                end
                beat_re[lane*16 +: 16] = acc_re;
                beat_im[lane*16 +: 16] = acc_im;
            end
            exp_re_q.push_back(beat_re);
            exp_im_q.push_back(beat_im);
            exp_last_q.push_back(in_last[0]);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic drive_idle(input int cycles);
        in_valid = '0;
        in_last = '0;
        repeat (cycles) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic wait_for_beats(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (beats_seen < target && cycles < limit) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (beats_seen < target) begin
            errors++;
            $display("timed out after %0d cycles with %0d of %0d output beats",
                     cycles, beats_seen, target);
            exp_re_q.delete();
            exp_im_q.delete();
            exp_last_q.delete();
        end
    endtask

    task automatic reset_state_check();
        start_case("idle outputs after reset");
        repeat (6) begin
            @(negedge clock);
            check_value("out_valid", {31'd0, out_valid}, 32'd0);
            check_value("out_last", {31'd0, out_last}, 32'd0);
        end
        @(posedge clock);
        #1;
    endtask

    // channel 0 weighted by one half, the others by zero
    task automatic half_weight_scaling();
        logic [BEAT_BITS-1:0] beat_re;
        logic [BEAT_BITS-1:0] beat_im;
        start_case("real half weight");
        randomize_inputs();
        for (int ch = 0; ch < CHANNELS; ch++) begin
            weight_re[ch] = (ch == 0) ? 8'sd64 : 8'sd0;
            weight_im[ch] = 8'sd0;
        end
        for (int lane = 0; lane < LANES; lane++) begin
            in_re[0][lane] = known_sample(lane);
            in_im[0][lane] = known_sample(lane + 3);
            beat_re[lane*16 +: 16] = in_re[0][lane] >>> 1;
            beat_im[lane*16 +: 16] = in_im[0][lane] >>> 1;
        end
        exp_re_q.push_back(beat_re);
        exp_im_q.push_back(beat_im);
        exp_last_q.push_back(1'b0);
        in_valid = '1;
        in_last = '0;
        drive_beat(1'b0);
        drive_idle(0);
        wait_for_beats(1, 20);
    endtask

    task automatic exact_latency();
        int   cycles;
        logic found;
        start_case("exact latency");
        randomize_inputs();
        in_valid = '1;
        in_last = '0;
        drive_beat(1'b1);
        drive_idle(0);
        // falling edges after the sampling edge, the third follows edge N+2
        cycles = 0;
        found = 1'b0;
        while (!found && cycles < 10) begin
            @(negedge clock);
            cycles++;
            found = out_valid;
        end
        if (!found) begin
            errors++;
            $display("timed out waiting for the single beat to come out");
        end else begin
            check_value("latency in falling edges", cycles, 32'd3);
        end
        @(negedge clock);
        check_value("out_valid after beat", {31'd0, out_valid}, 32'd0);
        @(posedge clock);
        #1;
    endtask

    task automatic streaming_random();
        start_case("streaming random beats");
        for (int beat = 0; beat < 10; beat++) begin
            randomize_inputs();
            in_valid = '1;
            in_last = '0;
            drive_beat(1'b1);
        end
        drive_idle(0);
        wait_for_beats(10, 40);
    endtask

    task automatic missing_channel();
        start_case("missing channel");
        for (int beat = 0; beat < 3; beat++) begin
            randomize_inputs();
            // channel 2 drops out of the middle beat
            in_valid = (beat == 1) ? 4'b1011 : 4'b1111;
            in_last = '0;
            drive_beat(1'b1);
        end
        drive_idle(0);
        wait_for_beats(2, 40);
        drive_idle(5);
        check_value("output beat count", beats_seen, 32'd2);
    endtask

    // channel 2 raises last early to show that only channel 0 counts
    task automatic last_propagation();
        start_case("last propagation");
        for (int beat = 0; beat < 4; beat++) begin
            randomize_inputs();
            in_valid = '1;
            in_last = (beat == 3) ? 4'b0001 : 4'b0100;
            drive_beat(1'b1);
        end
        drive_idle(0);
        wait_for_beats(4, 40);
    endtask

    initial begin
        clock = 1'b0;
        resetn = 1'b0;
        in_valid = '0;
        in_last = '0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            weight_re[ch] = '0;
            weight_im[ch] = '0;
            for (int lane = 0; lane < LANES; lane++) begin
                in_re[ch][lane] = '0;
                in_im[ch][lane] = '0;
            end
        end
        repeat (4) @(posedge clock);
        #1;
        resetn = 1'b1;

        reset_state_check();
        half_weight_scaling();
        exact_latency();
        streaming_random();
        missing_channel();
        last_propagation();
        drive_idle(4);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: project.f
+incdir+bench
verilog/bf_pkg.sv
verilog/bf_lane_cmul.sv
verilog/bf_channel.sv
verilog/bf_combiner.sv
verilog/bf_top.sv
bench/bf_tb.sv

// File: Makefile
# Verilator build and run for the beamforming combiner testbench

VERILATOR ?= verilator
TOP       ?= bf_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
